//--- tb.f
logic/ddr_maint_pkg.sv
logic/apb_map_pkg.sv
logic/maint_fifo.sv
logic/apb_maint_regs.sv
logic/maint_sequencer.sv
logic/ddr_maint_top.sv
tests/ddr_maint_sva.sv
tests/ddr_maint_tb.sv

//--- Bender.yml
package:
  name: ddr_maint

sources:
  - files:
      - logic/ddr_maint_pkg.sv
      - logic/apb_map_pkg.sv
      - logic/maint_fifo.sv
      - logic/apb_maint_regs.sv
      - logic/maint_sequencer.sv
      - logic/ddr_maint_top.sv
  - target: test
    files:
      - tests/ddr_maint_sva.sv
      - tests/ddr_maint_tb.sv

//--- tests/ddr_maint_tb.sv
// DDR3 maintenance wrapper testbench
module ddr_maint_tb;

  import ddr_maint_pkg::*;
  import apb_map_pkg::*;

  localparam int MAX_CYCLES = 4000;  // Calibration plus 40 ZQ commands, with margin

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              calib_done;
  logic              sr_active;

  int                errors;
  int                cycles;
  integer            seed;
  int                n_acc;        // Accepted commands, source of the expected tag
  int                exp_ref;
  int                exp_zq;
  int                n_ok;
  int                n_rej;
  int                calib_wait;
  int                calib_rise;
  bit                calib_seen;
  logic [APB_DW-1:0] rd;
  logic              err;
  maint_code_t       code;

  ddr_maint_top ddr_maint_top_i (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_psel(psel),
    .i_penable(penable),
    .i_pwrite(pwrite),
    .i_paddr(paddr),
    .i_pwdata(pwdata),
    .o_prdata(prdata),
    .o_pready(pready),
    .o_pslverr(pslverr),
    .o_init_calib_done(calib_done),
    .o_sr_active(sr_active)
  );

  bind ddr_maint_top ddr_maint_sva sva_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pslverr(o_pslverr),
    .i_calib_done(o_init_calib_done),
    .i_cmd_push(w_cmd_push),
    .i_cmd_full(w_cmd_full),
    .i_done_push(w_done_push),
    .i_done_full(w_done_full),
    .i_sr_active(o_sr_active)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Edges since reset release, seen at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (calib_done && !calib_seen) begin
        calib_seen = 1'b1;
        calib_rise = calib_wait;
      end
      calib_wait++;
    end
  end

  task automatic check_value(input string name, input logic [APB_DW-1:0] got,
                             input logic [APB_DW-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      errors++;
      $display("error at %0t: %s", $time, msg);
    end
  endtask

  // Setup phase, access phase, then bus idle
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
                          output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata  = prdata;  // PRDATA and PSLVERR hold only in the access cycle
    slverr = pslverr;
    check_value("PREADY", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input logic [APB_AW-1:0] addr, input string name,
                            input logic [APB_DW-1:0] exp);
    logic [APB_DW-1:0] data;
    logic              slverr;
    apb_xfer(1'b0, addr, '0, data, slverr);
    check_value({name, " PSLVERR"}, slverr, 0);
    check_value(name, data, exp);
  endtask

  task automatic issue_cmd(input maint_code_t c, output logic slverr);
    logic [APB_DW-1:0] unused;
    apb_xfer(1'b1, REG_CMD, APB_DW'(c), unused, slverr);
    if (!slverr) begin
      n_acc++;
    end
  endtask

  // Poll LAST_DONE until the given tag shows up
  task automatic wait_last_done(input int tag);
    logic [APB_DW-1:0] data;
    logic              slverr;
    do begin
      apb_xfer(1'b0, REG_LAST_DONE, '0, data, slverr);
    end while (data[7:4] != 4'(tag));
    @(negedge clk);
  endtask

  function automatic logic [APB_DW-1:0] last_done_word(input maint_code_t c, input int tag,
                                                       input logic rej);
    last_done_word      = '0;
    last_done_word[1:0] = c;
    last_done_word[7:4] = 4'(tag % 16);
    last_done_word[8]   = rej;
  endfunction

  initial begin
    errors     = 0;
    cycles     = 0;
    seed       = 32'hfff2;
    n_acc      = 0;
    exp_ref    = 0;
    exp_zq     = 0;
    calib_wait = 0;
    calib_rise = 0;
    calib_seen = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Calibration gates all traffic
    read_check(REG_STATUS, "STATUS", 0);
    read_check(REG_REF_CNT, "REF_CNT", 0);
    read_check(REG_ZQ_CNT, "ZQ_CNT", 0);
    read_check(REG_LAST_DONE, "LAST_DONE", 0);
    issue_cmd(REFRESH, err);
    check_true(err, "command write before calibration done returned no PSLVERR");
    while (!calib_seen) @(posedge clk);
    check_value("calibration cycles", calib_rise, CALIB_CYCLES);
    read_check(REG_STATUS, "STATUS", 32'h1);

    // Random refresh and ZQ stream, spaced wider than one ZQ command
    repeat (20) begin
      code = ($random(seed) & 1) ? ZQCAL : REFRESH;
      issue_cmd(code, err);
      check_value("PSLVERR", err, 0);
      if (code == ZQCAL) exp_zq++;
      else exp_ref++;
      repeat (ZQ_CYCLES) @(posedge clk);
    end
    wait_last_done(n_acc);
    read_check(REG_REF_CNT, "REF_CNT", exp_ref);
    read_check(REG_ZQ_CNT, "ZQ_CNT", exp_zq);
    read_check(REG_LAST_DONE, "LAST_DONE", last_done_word(code, n_acc, 1'b0));

    // Back-to-back writes fill the command queue
    n_ok  = 0;
    n_rej = 0;
    repeat (8) begin
      issue_cmd(ZQCAL, err);
      if (err) n_rej++;
      else n_ok++;
    end
    exp_zq += n_ok;
    check_true(n_ok >= MAINT_Q_DEPTH, "fewer back-to-back writes accepted than the queue depth");
    check_true(n_rej >= 1, "no back-to-back write was rejected on a full queue");
    wait_last_done(n_acc);
    read_check(REG_ZQ_CNT, "ZQ_CNT", exp_zq);
    read_check(REG_LAST_DONE, "LAST_DONE", last_done_word(ZQCAL, n_acc, 1'b0));

    // Self-refresh entry, refused refresh, exit
    issue_cmd(SR_ENTER, err);
    check_value("PSLVERR", err, 0);
    wait_last_done(n_acc);
    check_value("o_sr_active", sr_active, 1);
    read_check(REG_STATUS, "STATUS", 32'h3);
    issue_cmd(SR_ENTER, err);
    check_true(err, "second SR_ENTER during self-refresh returned no PSLVERR");
    issue_cmd(REFRESH, err);
    check_value("PSLVERR", err, 0);
    wait_last_done(n_acc);
    read_check(REG_LAST_DONE, "LAST_DONE", last_done_word(REFRESH, n_acc, 1'b1));
    read_check(REG_REF_CNT, "REF_CNT", exp_ref);
    issue_cmd(SR_EXIT, err);
    check_value("PSLVERR", err, 0);
    wait_last_done(n_acc);
    check_value("o_sr_active", sr_active, 0);
    read_check(REG_LAST_DONE, "LAST_DONE", last_done_word(SR_EXIT, n_acc, 1'b0));

    // Address decode
    apb_xfer(1'b0, 8'h20, '0, rd, err);
    check_true(err, "read of unmapped offset 0x20 returned no PSLVERR");
    check_value("PRDATA", rd, 0);
    apb_xfer(1'b1, REG_REF_CNT, 32'h5a, rd, err);
    check_true(err, "write to read-only REF_CNT returned no PSLVERR");
    read_check(REG_REF_CNT, "REF_CNT", exp_ref);

    $display("run complete: %0d check errors, %0d assertion failures",
             errors, ddr_maint_top_i.sva_i.fail_cnt);
    if (errors == 0 && ddr_maint_top_i.sva_i.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tests/ddr_maint_sva.sv
// Maintenance wrapper protocol checks
module ddr_maint_sva (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_psel,
  input logic i_penable,
  input logic i_pslverr,
  input logic i_calib_done,
  input logic i_cmd_push,
  input logic i_cmd_full,
  input logic i_done_push,
  input logic i_done_full,
  input logic i_sr_active
);

  int fail_cnt;

  initial fail_cnt = 0;

  a_slverr_in_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pslverr |-> (i_psel && i_penable))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("PSLVERR high outside an access cycle");
    end

  // Calibration done is sticky until reset
  a_calib_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_calib_done |=> i_calib_done)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("calibration done fell");
    end

  a_cmd_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_cmd_push && i_cmd_full))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("command queue pushed while full");
    end

  a_done_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_done_push && i_done_full))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("completion queue pushed while full");
    end

  a_sr_with_push: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $changed(i_sr_active) |-> i_done_push)  // SR state moves with its completion
    else begin
      fail_cnt = fail_cnt + 1;
      $error("self-refresh changed without a completion");
    end

endmodule

//--- logic/ddr_maint_top.sv
// DDR3 maintenance wrapper top
module ddr_maint_top (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [apb_map_pkg::APB_AW-1:0] i_paddr,
  input  logic [apb_map_pkg::APB_DW-1:0] i_pwdata,
  output logic [apb_map_pkg::APB_DW-1:0] o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr,
  output logic                           o_init_calib_done,
  output logic                           o_sr_active
);

  import ddr_maint_pkg::*;

  logic        w_cmd_push;
  logic        w_cmd_full;
  logic        w_cmd_pop;
  logic        w_cmd_empty;
  maint_cmd_t  wb_cmd_in;
  maint_cmd_t  wb_cmd_out;
  logic        w_done_push;
  logic        w_done_full;
  logic        w_done_pop;
  logic        w_done_empty;
  maint_done_t wb_done_in;
  maint_done_t wb_done_out;

  apb_maint_regs regs0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr),
    .i_pwdata(i_pwdata),
    .o_prdata(o_prdata),
    .o_pready(o_pready),
    .o_pslverr(o_pslverr),
    .o_cmd_push(w_cmd_push),
    .o_cmd(wb_cmd_in),
    .i_cmd_full(w_cmd_full),
    .i_done_valid(!w_done_empty),
    .i_done(wb_done_out),
    .o_done_pop(w_done_pop),
    .i_calib_done(o_init_calib_done),
    .i_sr_active(o_sr_active)
  );

  // Software commands toward the engine
  maint_fifo #(
    .DEPTH(MAINT_Q_DEPTH),
    .T_DATA(maint_cmd_t)
  ) cmd_q (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_push(w_cmd_push),
    .i_data(wb_cmd_in),
    .o_full(w_cmd_full),
    .i_pop(w_cmd_pop),
    .o_data(wb_cmd_out),
    .o_empty(w_cmd_empty)
  );

  // Completions back to the registers
  maint_fifo #(
    .DEPTH(MAINT_Q_DEPTH),
    .T_DATA(maint_done_t)
  ) done_q (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_push(w_done_push),
    .i_data(wb_done_in),
    .o_full(w_done_full),
    .i_pop(w_done_pop),
    .o_data(wb_done_out),
    .o_empty(w_done_empty)
  );

  maint_sequencer seq0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_cmd_valid(!w_cmd_empty),
    .i_cmd(wb_cmd_out),
    .o_cmd_pop(w_cmd_pop),
    .o_done_push(w_done_push),
    .o_done(wb_done_in),
    .i_done_full(w_done_full),
    .o_calib_done(o_init_calib_done),
    .o_sr_active(o_sr_active)
  );

endmodule

//--- logic/maint_sequencer.sv
// DDR3 maintenance engine model
module maint_sequencer (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_cmd_valid,
  input  ddr_maint_pkg::maint_cmd_t  i_cmd,
  output logic                       o_cmd_pop,
  output logic                       o_done_push,
  output ddr_maint_pkg::maint_done_t o_done,
  input  logic                       i_done_full,
  output logic                       o_calib_done,
  output logic                       o_sr_active
);

  import ddr_maint_pkg::*;

  typedef enum logic [1:0] {
    ST_CALIB,
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } state_t;

  state_t             state;
  logic [CALIB_W-1:0] calib_cnt;
  logic [BUSY_W-1:0]  busy_cnt;
  logic [BUSY_W-1:0]  busy_load;
  maint_cmd_t         cmd_q;
  logic               reject_q;
  logic               calib_done_q;
  logic               sr_q;
  logic               rej_now;

  // Refresh and ZQ are not legal while the DRAM sits in self-refresh
  assign rej_now = sr_q && ((i_cmd.code == REFRESH) || (i_cmd.code == ZQCAL));

  always_comb begin
    case (i_cmd.code)
      REFRESH: busy_load = BUSY_W'(REF_CYCLES - 1);
      ZQCAL:   busy_load = BUSY_W'(ZQ_CYCLES - 1);
      default: busy_load = BUSY_W'(SR_CYCLES - 1);
    endcase
    if (rej_now) begin
      busy_load = BUSY_W'(SR_CYCLES - 1);  // Refusal takes the short time
    end
  end

  // Take a command only when its completion is sure to fit
  assign o_cmd_pop     = (state == ST_IDLE) && i_cmd_valid && !i_done_full;
  assign o_done_push   = (state == ST_DONE);
  assign o_done.code   = cmd_q.code;
  assign o_done.tag    = cmd_q.tag;
  assign o_done.reject = reject_q;
  assign o_calib_done  = calib_done_q;
  assign o_sr_active   = sr_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state        <= ST_CALIB;
      calib_cnt    <= '0;
      calib_done_q <= 1'b0;
      busy_cnt     <= '0;
      reject_q     <= 1'b0;
      sr_q         <= 1'b0;
    end else begin
      case (state)
        ST_CALIB: begin
          calib_cnt <= calib_cnt + 1'b1;
          if (calib_cnt == CALIB_W'(CALIB_CYCLES - 1)) begin
            calib_done_q <= 1'b1;  // Stays high until reset
            state        <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (o_cmd_pop) begin
            busy_cnt <= busy_load;
            reject_q <= rej_now;
            state    <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (busy_cnt == '0) begin
            // SR state turns over together with the completion push
            if (cmd_q.code == SR_ENTER) begin
              sr_q <= 1'b1;
            end else if (cmd_q.code == SR_EXIT) begin
              sr_q <= 1'b0;
            end
            state <= ST_DONE;
          end else begin
            busy_cnt <= busy_cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;  // ST_DONE, completion pushed
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_cmd_pop) begin
      cmd_q <= i_cmd;
    end
  end

endmodule

//--- logic/apb_maint_regs.sv
// APB maintenance register block
module apb_maint_regs (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [apb_map_pkg::APB_AW-1:0] i_paddr,
  input  logic [apb_map_pkg::APB_DW-1:0] i_pwdata,
  output logic [apb_map_pkg::APB_DW-1:0] o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr,
  output logic                           o_cmd_push,
  output ddr_maint_pkg::maint_cmd_t      o_cmd,
  input  logic                           i_cmd_full,
  input  logic                           i_done_valid,
  input  ddr_maint_pkg::maint_done_t     i_done,
  output logic                           o_done_pop,
  input  logic                           i_calib_done,
  input  logic                           i_sr_active
);

  import ddr_maint_pkg::*;
  import apb_map_pkg::*;

  logic                   access;
  logic                   acc_err;
  logic                   cmd_err;
  logic [APB_DW-1:0]      rdata;
  maint_code_t            wr_code;
  logic [MAINT_TAG_W-1:0] tag_cnt;
  logic [APB_DW-1:0]      ref_cnt;
  logic [APB_DW-1:0]      zq_cnt;
  maint_done_t            last_done;

  assign access  = i_psel && i_penable;
  assign wr_code = maint_code_t'(i_pwdata[1:0]);

  // Command refused before calibration, on a full queue or a repeated SR entry
  assign cmd_err = !i_calib_done || i_cmd_full || ((wr_code == SR_ENTER) && i_sr_active);

  always_comb begin
    rdata   = '0;
    acc_err = 1'b0;
    case (i_paddr)
      REG_STATUS: begin
        rdata[STAT_CALIB_BIT] = i_calib_done;
        rdata[STAT_SR_BIT]    = i_sr_active;
        rdata[STAT_FULL_BIT]  = i_cmd_full;
        acc_err               = i_pwrite;
      end
      REG_CMD: begin
        acc_err = i_pwrite ? cmd_err : 1'b1;  // Reading back a command is an error
      end
      REG_REF_CNT: begin
        rdata   = ref_cnt;
        acc_err = i_pwrite;
      end
      REG_ZQ_CNT: begin
        rdata   = zq_cnt;
        acc_err = i_pwrite;
      end
      REG_LAST_DONE: begin
        rdata[LD_CODE_LSB +: 2]          = last_done.code;
        rdata[LD_TAG_LSB +: MAINT_TAG_W] = last_done.tag;
        rdata[LD_REJ_BIT]                = last_done.reject;
        acc_err                          = i_pwrite;
      end
      default: acc_err = 1'b1;  // Unmapped
    endcase
  end

  // Zero-wait slave
  assign o_pready  = 1'b1;
  assign o_pslverr = access && acc_err;
  assign o_prdata  = (access && !i_pwrite && !acc_err) ? rdata : '0;

  // Tag is the running count of accepted commands, this one included
  assign o_cmd_push = access && i_pwrite && (i_paddr == REG_CMD) && !cmd_err;
  assign o_cmd.code = wr_code;
  assign o_cmd.tag  = tag_cnt + 1'b1;

  assign o_done_pop = i_done_valid;  // Drain every completion at once

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      tag_cnt   <= '0;
      ref_cnt   <= '0;
      zq_cnt    <= '0;
      last_done <= '0;
    end else begin
      if (o_cmd_push) begin
        tag_cnt <= tag_cnt + 1'b1;
      end
      if (i_done_valid) begin
        last_done <= i_done;
        // Rejected completions are not counted
        if (!i_done.reject && (i_done.code == REFRESH)) begin
          ref_cnt <= ref_cnt + 1'b1;
        end
        if (!i_done.reject && (i_done.code == ZQCAL)) begin
          zq_cnt <= zq_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/maint_fifo.sv
// First-word fall-through queue
module maint_fifo #(
  parameter int  DEPTH  = 4,
  parameter type T_DATA = logic [7:0]
) (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_push,
  input  T_DATA i_data,
  output logic  o_full,
  input  logic  i_pop,
  output T_DATA o_data,
  output logic  o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_empty = (count == '0);
  assign o_data  = mem[rd_ptr];  // Head shown without a pop

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

endmodule

//--- logic/apb_map_pkg.sv
// APB register map
package apb_map_pkg;

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Register offsets
  localparam logic [APB_AW-1:0] REG_STATUS    = 8'h00;  // RO
  localparam logic [APB_AW-1:0] REG_CMD       = 8'h04;  // WO
  localparam logic [APB_AW-1:0] REG_REF_CNT   = 8'h08;  // RO
  localparam logic [APB_AW-1:0] REG_ZQ_CNT    = 8'h0C;  // RO
  localparam logic [APB_AW-1:0] REG_LAST_DONE = 8'h10;  // RO

  // STATUS bits
  localparam int STAT_CALIB_BIT = 0;
  localparam int STAT_SR_BIT    = 1;
  localparam int STAT_FULL_BIT  = 2;

  // LAST_DONE fields
  localparam int LD_CODE_LSB = 0;
  localparam int LD_TAG_LSB  = 4;
  localparam int LD_REJ_BIT  = 8;

endpackage

//--- logic/ddr_maint_pkg.sv
// DDR3 maintenance path definitions
package ddr_maint_pkg;

  // Maintenance command codes as written to REG_CMD
  typedef enum logic [1:0] {
    SR_EXIT  = 2'd0,
    REFRESH  = 2'd1,
    ZQCAL    = 2'd2,
    SR_ENTER = 2'd3
  } maint_code_t;

  localparam int MAINT_TAG_W = 4;

  typedef struct packed {
    maint_code_t            code;
    logic [MAINT_TAG_W-1:0] tag;
  } maint_cmd_t;

  typedef struct packed {
    maint_code_t            code;
    logic [MAINT_TAG_W-1:0] tag;
    logic                   reject;  // Command refused by the engine
  } maint_done_t;

  localparam int MAINT_Q_DEPTH = 4;

  // Busy times in controller clock cycles
  localparam int CALIB_CYCLES = 64;
  localparam int REF_CYCLES   = 8;
  localparam int ZQ_CYCLES    = 16;
  localparam int SR_CYCLES    = 4;

  localparam int CALIB_W = $clog2(CALIB_CYCLES);
  localparam int BUSY_W  = $clog2(ZQ_CYCLES);  // ZQ is the longest busy time

endpackage
